// ==== common/mem_stage_macros.svh ====
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// data path and address width
`define MEM_XLEN 64

// destination register number width
`define MEM_REGNO_W 5

// byte offset inside one doubleword
`define MEM_OFS_W 3

// bits per byte, used to turn byte offsets into bit shifts
`define MEM_BYTE_W 8

// field widths of the sub-word accesses
`define MEM_HALF_W 16
`define MEM_WORD_W 32

`endif

// ==== common/mem_stage_pkg.sv ====
`include "mem_stage_macros.svh"

package mem_stage_pkg;

  typedef logic [`MEM_XLEN-1:0] xlen_t;
  typedef logic [`MEM_REGNO_W-1:0] regno_t;
  typedef logic [`MEM_OFS_W-1:0] byte_ofs_t;

  typedef enum logic [3:0] {
    op_none,
    op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld,
    op_sb, op_sh, op_sw, op_sd
  } mem_op_t;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } ctrl_state_t;

  function automatic logic is_load(mem_op_t op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic is_store(mem_op_t op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  // sub-word stores go through a read-modify-write
  function automatic logic needs_rmw(mem_op_t op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // drops the offset bits below the access size
  function automatic byte_ofs_t align_ofs(mem_op_t op, byte_ofs_t ofs);
    case (op)
      op_lh, op_lhu, op_sh: return ofs & ~byte_ofs_t'(1);
      op_lw, op_lwu, op_sw: return ofs & ~byte_ofs_t'(3);
      op_ld, op_sd:         return '0;
      default:              return ofs;
    endcase
  endfunction

endpackage

// ==== rtl/load_align.sv ====
`include "mem_stage_macros.svh"

module load_align (
  input  mem_stage_pkg::mem_op_t   op,
  input  mem_stage_pkg::byte_ofs_t ofs,
  input  mem_stage_pkg::xlen_t     rdata,
  output mem_stage_pkg::xlen_t     value
);
  import mem_stage_pkg::*;

  byte_ofs_t ofs_al;
  xlen_t     field;   // addressed field moved down to bit 0

  assign ofs_al = align_ofs(op, ofs);
  assign field  = rdata >> {ofs_al, 3'b000};

  always_comb begin
    case (op)
      op_lb: begin
        value = {{(`MEM_XLEN-`MEM_BYTE_W){field[`MEM_BYTE_W-1]}},
                 field[`MEM_BYTE_W-1:0]};
      end
      op_lbu: begin
        value = {{(`MEM_XLEN-`MEM_BYTE_W){1'b0}}, field[`MEM_BYTE_W-1:0]};
      end
      op_lh: begin
        value = {{(`MEM_XLEN-`MEM_HALF_W){field[`MEM_HALF_W-1]}},
                 field[`MEM_HALF_W-1:0]};
      end
      op_lhu: begin
        value = {{(`MEM_XLEN-`MEM_HALF_W){1'b0}}, field[`MEM_HALF_W-1:0]};
      end
      op_lw: begin
        value = {{(`MEM_XLEN-`MEM_WORD_W){field[`MEM_WORD_W-1]}},
                 field[`MEM_WORD_W-1:0]};
      end
      op_lwu: begin
        value = {{(`MEM_XLEN-`MEM_WORD_W){1'b0}}, field[`MEM_WORD_W-1:0]};
      end
      op_ld:   value = rdata;   // whole doubleword
      default: value = '0;
    endcase
  end

endmodule

// ==== rtl/store_merge.sv ====
`include "mem_stage_macros.svh"

module store_merge (
  input  mem_stage_pkg::mem_op_t   op,
  input  mem_stage_pkg::byte_ofs_t ofs,
  input  mem_stage_pkg::xlen_t     rdata,
  input  mem_stage_pkg::xlen_t     store_value,
  output mem_stage_pkg::xlen_t     merged
);
  import mem_stage_pkg::*;

  byte_ofs_t ofs_al;
  xlen_t     size_mask;   // ones over the access size, at bit 0
  xlen_t     lane_mask;
  xlen_t     lane_data;

  assign ofs_al = align_ofs(op, ofs);

  always_comb begin
    case (op)
      op_sb:   size_mask = {{(`MEM_XLEN-`MEM_BYTE_W){1'b0}}, {`MEM_BYTE_W{1'b1}}};
      op_sh:   size_mask = {{(`MEM_XLEN-`MEM_HALF_W){1'b0}}, {`MEM_HALF_W{1'b1}}};
      op_sw:   size_mask = {{(`MEM_XLEN-`MEM_WORD_W){1'b0}}, {`MEM_WORD_W{1'b1}}};
      default: size_mask = '0;  // nothing replaced, rdata comes back as is
    endcase
  end

  assign lane_mask = size_mask << {ofs_al, 3'b000};
  assign lane_data = (store_value & size_mask) << {ofs_al, 3'b000};

  // keep the other bytes of the doubleword
  assign merged = (rdata & ~lane_mask) | lane_data;

endmodule

// ==== rtl/mem_ctrl.sv ====
`include "mem_stage_macros.svh"

module mem_ctrl (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   valid,
  input  mem_stage_pkg::mem_op_t op,
  input  mem_stage_pkg::xlen_t   addr,
  input  mem_stage_pkg::xlen_t   rs2_value,
  input  mem_stage_pkg::regno_t  rd_regno,
  input  logic                   update_rd,

  // from load_align and store_merge
  input  mem_stage_pkg::xlen_t   load_value,
  input  mem_stage_pkg::xlen_t   merged_value,

  input  logic                   wb_ack,

  output logic                   ready,
  output logic                   result_valid,
  output mem_stage_pkg::xlen_t   mdata,
  output mem_stage_pkg::xlen_t   alu_result_out,
  output mem_stage_pkg::regno_t  rd_regno_out,
  output logic                   update_rd_out,

  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output mem_stage_pkg::xlen_t   wb_adr,
  output mem_stage_pkg::xlen_t   wb_dat_w
);
  import mem_stage_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  xlen_t       merged_q;      // doubleword to write back for sb/sh/sw

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (valid) begin
          if (is_load(op) || needs_rmw(op)) begin
            state_nxt = st_read;
          end else if (is_store(op)) begin
            state_nxt = st_write;   // sd writes without reading first
          end
        end
      end
      st_read: begin
        if (wb_ack) begin
          state_nxt = needs_rmw(op) ? st_write : st_idle;
        end
      end
      st_write: begin
        if (wb_ack) begin
          state_nxt = st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // accept: op_none at once, memory ops on their last ack
  always_comb begin
    case (state)
      st_idle:  ready = valid && !is_load(op) && !is_store(op);
      st_read:  ready = wb_ack && !needs_rmw(op);
      st_write: ready = wb_ack;
      default:  ready = 1'b0;
    endcase
  end

  // bus signals come from the state register only, so they hold until ack
  assign wb_cyc   = (state == st_read) || (state == st_write);
  assign wb_stb   = wb_cyc;
  assign wb_we    = (state == st_write);
  assign wb_adr   = {addr[`MEM_XLEN-1:`MEM_OFS_W], {`MEM_OFS_W{1'b0}}}; // doubleword aligned
  assign wb_dat_w = needs_rmw(op) ? merged_q : rs2_value;

  // capture the merged doubleword at the read ack
  always_ff @(posedge clk) begin
    if (state == st_read && wb_ack && needs_rmw(op)) begin
      merged_q <= merged_value;
    end
  end

  // output stage register
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid   <= 1'b0;
      mdata          <= '0;
      alu_result_out <= '0;
      rd_regno_out   <= '0;
      update_rd_out  <= 1'b0;
    end else begin
      result_valid <= ready;  // one cycle pulse per accepted op
      if (ready) begin
        mdata          <= is_load(op) ? load_value : '0;
        alu_result_out <= addr;
        rd_regno_out   <= rd_regno;
        update_rd_out  <= update_rd;
      end
    end
  end

endmodule

// ==== rtl/mem_stage.sv ====
`include "mem_stage_macros.svh"

module mem_stage (
  input  logic                   clk,
  input  logic                   reset,

  // pipeline side
  input  logic                   valid,
  input  mem_stage_pkg::mem_op_t op,
  input  mem_stage_pkg::xlen_t   addr,
  input  mem_stage_pkg::xlen_t   rs2_value,
  input  mem_stage_pkg::regno_t  rd_regno,
  input  logic                   update_rd,
  output logic                   ready,
  output logic                   result_valid,
  output mem_stage_pkg::xlen_t   mdata,
  output mem_stage_pkg::xlen_t   alu_result_out,
  output mem_stage_pkg::regno_t  rd_regno_out,
  output logic                   update_rd_out,

  // wishbone classic master
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output mem_stage_pkg::xlen_t   wb_adr,
  output mem_stage_pkg::xlen_t   wb_dat_w,
  input  mem_stage_pkg::xlen_t   wb_dat_r,
  input  logic                   wb_ack
);
  import mem_stage_pkg::*;

  byte_ofs_t ofs;           // byte position inside the doubleword
  xlen_t     load_value;
  xlen_t     merged_value;

  assign ofs = addr[`MEM_OFS_W-1:0];

  mem_ctrl ctrl_i (
    .clk            (clk),
    .reset          (reset),
    .valid          (valid),
    .op             (op),
    .addr           (addr),
    .rs2_value      (rs2_value),
    .rd_regno       (rd_regno),
    .update_rd      (update_rd),
    .load_value     (load_value),
    .merged_value   (merged_value),
    .wb_ack         (wb_ack),
    .ready          (ready),
    .result_valid   (result_valid),
    .mdata          (mdata),
    .alu_result_out (alu_result_out),
    .rd_regno_out   (rd_regno_out),
    .update_rd_out  (update_rd_out),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w)
  );

  // extraction works straight off the bus read data
  load_align align_i (
    .op    (op),
    .ofs   (ofs),
    .rdata (wb_dat_r),
    .value (load_value)
  );

  store_merge merge_i (
    .op          (op),
    .ofs         (ofs),
    .rdata       (wb_dat_r),
    .store_value (rs2_value),
    .merged      (merged_value)
  );

endmodule

// ==== verification/mem_stage_asserts.sv ====
module mem_stage_asserts (
  input logic                       clk,
  input logic                       reset,
  input mem_stage_pkg::ctrl_state_t state,
  input logic                       ready,
  input logic                       result_valid,
  input logic                       wb_cyc,
  input logic                       wb_stb,
  input logic                       wb_we,
  input mem_stage_pkg::xlen_t       wb_adr,
  input mem_stage_pkg::xlen_t       wb_dat_w,
  input logic                       wb_ack
);
  import mem_stage_pkg::*;

  int fail_count;   // failed assertions so far

  stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
    else begin
      $error("wb_stb high while wb_cyc is low");
      fail_count++;
    end

  // the request holds until the slave acks it
  req_stable: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w))
    else begin
      $error("bus request changed while waiting for ack");
      fail_count++;
    end

  ready_ok: assert property (@(posedge clk) disable iff (reset)
    ready |-> (state == st_idle) || wb_ack)
    else begin
      $error("ready high outside idle and without ack");
      fail_count++;
    end

  result_after_ready: assert property (@(posedge clk) disable iff (reset)
    ready |=> result_valid)
    else begin
      $error("result_valid missing one cycle after ready");
      fail_count++;
    end

  result_only_after_ready: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> $past(ready))
    else begin
      $error("result_valid without ready in the cycle before");
      fail_count++;
    end

endmodule

// ==== verification/mem_stage_tb.sv ====
`include "mem_stage_macros.svh"

module mem_stage_tb;
  import mem_stage_pkg::*;

  localparam int clk_period = 20;
  localparam int mem_words  = 64;
  localparam int idx_w      = $clog2(mem_words);
  localparam int dw_bytes   = `MEM_XLEN / `MEM_BYTE_W;
  localparam int n_random   = 200;
  localparam int n_ops      = 2 + 58 + 2 + 28 + n_random;  // all operations issued
  localparam int timeout    = (n_ops * 20 + 100) * clk_period;

  logic    clk;
  logic    reset;
  logic    valid;
  mem_op_t op;
  xlen_t   addr;
  xlen_t   rs2_value;
  regno_t  rd_regno;
  logic    update_rd;
  logic    ready;
  logic    result_valid;
  xlen_t   mdata;
  xlen_t   alu_result_out;
  regno_t  rd_regno_out;
  logic    update_rd_out;
  logic    wb_cyc;
  logic    wb_stb;
  logic    wb_we;
  xlen_t   wb_adr;
  xlen_t   wb_dat_w;
  xlen_t   wb_dat_r;
  logic    wb_ack;

  xlen_t       mem [mem_words];
  xlen_t       shadow [mem_words];  // expected memory contents
  int unsigned waits;               // wait states left in the current bus cycle
  logic        started;
  int          write_count;
  int          cyc_cycles;
  int          checks;
  int          errors;

  mem_stage mem_stage_i (.*);

  bind mem_ctrl mem_stage_asserts asserts_i (
    .clk(clk), .reset(reset), .state(state), .ready(ready), .result_valid(result_valid),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_ack(wb_ack)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic int word_index(xlen_t a);
    return int'(a[`MEM_OFS_W +: idx_w]);
  endfunction

  // wishbone slave with zero to three wait states per cycle
  always @(posedge clk) begin
    if (reset) begin
      wb_ack  <= 1'b0;
      started <= 1'b0;
    end else if (wb_ack) begin
      wb_ack  <= 1'b0;
      started <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!started) begin
        waits = $urandom_range(3, 0);
        started <= 1'b1;
      end
      if (waits == 0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          mem[word_index(wb_adr)] <= wb_dat_w;
          write_count <= write_count + 1;
        end else begin
          wb_dat_r <= mem[word_index(wb_adr)];
        end
      end else begin
        waits = waits - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (wb_cyc) cyc_cycles <= cyc_cycles + 1;
  end

  // the tag leaves each byte's sign bit alone and follows the entry
  function automatic xlen_t fill_word(int idx);
    logic [7:0] tag;
    tag = {2'b00, idx[5:0]};
    return 64'hF8E7_1685_7463_D2C1 ^ {dw_bytes{tag}};
  endfunction

  function automatic int access_size(mem_op_t o);
    case (o)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return dw_bytes;
    endcase
  endfunction

  // built byte by byte from the offset rounded down to the access size
  function automatic xlen_t expect_load(mem_op_t o, xlen_t dw, int ofs);
    int    size;
    int    base;
    int    i;
    xlen_t r;
    size = access_size(o);
    base = ofs - ofs % size;
    r    = '0;
    for (i = 0; i < size; i++) r[i*8 +: 8] = dw[(base+i)*8 +: 8];
    if ((o inside {op_lb, op_lh, op_lw}) && r[size*8-1]) begin
      for (i = size * 8; i < `MEM_XLEN; i++) r[i] = 1'b1;
    end
    return r;
  endfunction

  function automatic xlen_t expect_store(mem_op_t o, xlen_t dw, int ofs, xlen_t v);
    int    size;
    int    base;
    int    i;
    xlen_t r;
    size = access_size(o);
    base = ofs - ofs % size;
    r    = dw;
    for (i = 0; i < size; i++) r[(base+i)*8 +: 8] = v[i*8 +: 8];
    return r;
  endfunction

  task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic check_regno(input string what, input regno_t exp, input regno_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %0d, actual %0d", what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  // returns at the negedge after the accepting edge when the outputs are stable
  task automatic run_op(input string what, input mem_op_t o, input xlen_t a, input xlen_t v,
                        input regno_t rd, input logic upd);
    @(posedge clk);
    valid     <= 1'b1;
    op        <= o;
    addr      <= a;
    rs2_value <= v;
    rd_regno  <= rd;
    update_rd <= upd;
    @(negedge clk);
    while (!ready) @(negedge clk);
    @(posedge clk);
    valid <= 1'b0;
    op    <= op_none;
    @(negedge clk);
    check_flag({what, " result_valid"}, 1'b1, result_valid);
  endtask

  task automatic pass_through_ops();
    int cyc_before;
    cyc_before = cyc_cycles;
    run_op("pass_through", op_none, 64'h8000_1234_5678_9ABC, 64'h1, 5'd17, 1'b1);
    check_xlen("pass_through alu", 64'h8000_1234_5678_9ABC, alu_result_out);
    check_regno("pass_through rd", 5'd17, rd_regno_out);
    check_flag("pass_through update", 1'b1, update_rd_out);
    check_xlen("pass_through mdata", '0, mdata);
    run_op("pass_through", op_none, 64'h40, 64'h2, 5'd3, 1'b0);
    check_xlen("pass_through alu", 64'h40, alu_result_out);
    check_regno("pass_through rd", 5'd3, rd_regno_out);
    check_flag("pass_through update", 1'b0, update_rd_out);
    check_xlen("pass_through bus cycles", '0, xlen_t'(cyc_cycles - cyc_before));
  endtask

  task automatic sweep_loads(input int e);
    mem_op_t o;
    int      k;
    int      ofs;
    string   what;
    for (k = int'(op_lb); k <= int'(op_ld); k++) begin
      o = mem_op_t'(k);
      for (ofs = 0; ofs < dw_bytes; ofs += access_size(o)) begin
        what = $sformatf("loads %s ofs %0d", o.name(), ofs);
        run_op(what, o, xlen_t'(e * dw_bytes + ofs), '0, regno_t'(k), 1'b1);
        check_xlen(what, expect_load(o, shadow[e], ofs), mdata);
        check_regno(what, regno_t'(k), rd_regno_out);
      end
    end
  endtask

  task automatic store_and_read_double(input int e);
    xlen_t v;
    int    writes_before;
    v = {$urandom, $urandom};
    writes_before = write_count;
    run_op("sd", op_sd, xlen_t'(e * dw_bytes), v, 5'd9, 1'b0);
    shadow[e] = v;
    check_xlen("sd mdata", '0, mdata);
    check_xlen("sd write count", 64'd1, xlen_t'(write_count - writes_before));
    run_op("sd readback", op_ld, xlen_t'(e * dw_bytes), '0, 5'd9, 1'b1);
    check_xlen("sd readback", v, mdata);
  endtask

  task automatic sweep_sub_stores(input int e);
    mem_op_t o;
    int      k;
    int      ofs;
    xlen_t   v;
    string   what;
    for (k = int'(op_sb); k <= int'(op_sw); k++) begin
      o = mem_op_t'(k);
      for (ofs = 0; ofs < dw_bytes; ofs += access_size(o)) begin
        what = $sformatf("sub_stores %s ofs %0d", o.name(), ofs);
        v    = {$urandom, $urandom};
        run_op(what, o, xlen_t'(e * dw_bytes + ofs), v, '0, 1'b0);
        shadow[e] = expect_store(o, shadow[e], ofs, v);
        check_xlen(what, '0, mdata);
        run_op(what, op_ld, xlen_t'(e * dw_bytes), '0, '0, 1'b1);
        check_xlen(what, shadow[e], mdata);
      end
    end
  endtask

  task automatic random_mix(input int n);
    mem_op_t o;
    xlen_t   a;
    xlen_t   v;
    int      e;
    int      ofs;
    int      i;
    string   what;
    for (i = 0; i < n; i++) begin
      o   = mem_op_t'($urandom_range(int'(op_sd), int'(op_lb)));
      e   = $urandom_range(mem_words - 1, 0);
      ofs = $urandom_range(dw_bytes - 1, 0);
      a   = {$urandom, $urandom};  // upper bits alias onto the model
      a[`MEM_OFS_W +: idx_w] = e[idx_w-1:0];
      a[`MEM_OFS_W-1:0]      = ofs[`MEM_OFS_W-1:0];
      v   = {$urandom, $urandom};
      what = $sformatf("random #%0d %s", i, o.name());
      run_op(what, o, a, v, regno_t'(i), 1'b1);
      if (o inside {op_sb, op_sh, op_sw, op_sd}) begin
        shadow[e] = expect_store(o, shadow[e], ofs, v);
        check_xlen(what, '0, mdata);
      end else begin
        check_xlen(what, expect_load(o, shadow[e], ofs), mdata);
      end
      check_xlen({what, " alu"}, a, alu_result_out);
    end
  endtask

  initial begin
    int i;
    void'($urandom(32'h6427_12df));
    clk         = 1'b0;
    reset       = 1'b1;
    valid       = 1'b0;
    op          = op_none;
    addr        = '0;
    rs2_value   = '0;
    rd_regno    = '0;
    update_rd   = 1'b0;
    wb_dat_r    = '0;
    wb_ack      = 1'b0;
    started     = 1'b0;
    waits       = 0;
    write_count = 0;
    cyc_cycles  = 0;
    checks      = 0;
    errors      = 0;
    for (i = 0; i < mem_words; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = mem[i];
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    sweep_loads(3);
    pass_through_ops();   // mdata holds load data before this
    sweep_loads(42);
    store_and_read_double(17);
    sweep_sub_stores(29);
    random_mix(n_random);

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             mem_stage_i.ctrl_i.asserts_i.fail_count);
    if (errors == 0 && mem_stage_i.ctrl_i.asserts_i.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout);
    $display("timeout: the memory stage stopped completing operations");
    $display("Something failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/mem_stage_pkg.sv
rtl/load_align.sv
rtl/store_merge.sv
rtl/mem_ctrl.sv
rtl/mem_stage.sv
verification/mem_stage_asserts.sv
verification/mem_stage_tb.sv
